// File: verilog/axi_wr_pkg.sv
// -------------------------------------------------------------------------
// AXI write channel definitions for the DDR dump engine
// widths of the write master and the fixed burst attributes it relies on
// -------------------------------------------------------------------------

package axi_wr_pkg;

    localparam int AXI_DW          = 64;   // data width
    localparam int AXI_AW          = 32;   // address width
    localparam int AXI_IW          = 6;    // id width
    localparam int AXI_BEATS       = 16;   // beats per burst
    localparam int AXI_BURST_BYTES = 128;  // AXI_BEATS * 8 bytes
    localparam int AXI_ID_MAX      = 8;    // upper limit of the id pool

    // fixed burst attributes seen by the interconnect
    localparam logic [2:0]          AXI_AWSIZE  = 3'b011;  // 8 bytes per beat
    localparam logic [3:0]          AXI_AWLEN   = 4'(AXI_BEATS - 1);
    localparam logic [1:0]          AXI_AWBURST = 2'b01;   // INCR
    localparam logic [3:0]          AXI_AWCACHE = 4'b0001; // bufferable, not cacheable
    localparam logic [2:0]          AXI_AWPROT  = 3'b000;  // normal, secure, data
    localparam logic [3:0]          AXI_AWQOS   = 4'd0;
    localparam logic [1:0]          AXI_AWLOCK  = 2'b00;   // normal access
    localparam logic [AXI_DW/8-1:0] AXI_WSTRB   = '1;      // all bytes written

endpackage

// File: verilog/dump_buf_pkg.sv
// -------------------------------------------------------------------------
// sample buffer definitions for the DDR dump engine
// half-buffer geometry, half index encoding, read address views and the
// DDR ring step per dumped half
// -------------------------------------------------------------------------

package dump_buf_pkg;

    localparam int BUF_AW     = 12;     // buffer read address width
    localparam int HALF_BEATS = 2048;   // 64 bit beats per half-buffer
    localparam int RING_STEP  = 16384;  // bytes one half occupies in DDR

    // half-buffer index
    // bit 1 selects the channel (0 = A, 1 = B)
    // bit 0 selects the half (0 = low, 1 = high)
    typedef logic [1:0] half_id_t;

    // buffer read address, seen either as one flat counter or split into
    // the half, the burst within the half and the beat within the burst
    typedef union packed {
        logic [BUF_AW-1:0] flat;
        struct packed {
            logic       half;
            logic [6:0] burst;
            logic [3:0] beat;
        } f;
    } buf_addr_u;

endpackage

// File: verilog/half_buffer_tracker.sv
// -------------------------------------------------------------------------
// half-buffer tracker
// latches the ready pulses of enabled channels and offers the pending
// half with the highest priority (A-low, A-high, B-low, B-high)
// -------------------------------------------------------------------------

module half_buffer_tracker (
    input  logic                   buf_clk_i,
    input  logic                   buf_rstn_i,
    input  logic [3:0]             buf_ready_i,   // Al, Ah, Bl, Bh
    input  logic [1:0]             dump_en_i,     // A, B
    input  logic                   half_done_i,
    input  dump_buf_pkg::half_id_t done_half_i,
    output logic [3:0]             pending_o,
    output dump_buf_pkg::half_id_t next_half_o
);

    import dump_buf_pkg::*;

    logic [3:0] ready_q;  // one flag per half-buffer

    // ---------------------------------------------------------------------
    // ready flags
    always_ff @(posedge buf_clk_i) begin
        if (!buf_rstn_i) begin
            ready_q <= 4'b0000;
        end else begin
            for (int i = 0; i < 4; i++) begin
                // fresh data wins over the clear of an older dump
                if (buf_ready_i[i] && dump_en_i[i >> 1]) begin
                    ready_q[i] <= 1'b1;
                end else if (half_done_i && (done_half_i == half_id_t'(i))) begin
                    ready_q[i] <= 1'b0;
                end
            end
        end
    end

    assign pending_o = ready_q;

    // ---------------------------------------------------------------------
    // fixed priority pick, lowest index first
    always_comb begin
        next_half_o = half_id_t'(0);
        for (int i = 3; i >= 0; i--) begin
            if (ready_q[i]) begin
                next_half_o = half_id_t'(i);
            end
        end
    end

endmodule

// File: verilog/write_id_pool.sv
// -------------------------------------------------------------------------
// write id pool
// keeps one busy flag per AXI write id, hands out the lowest free id and
// releases an id when its write response arrives
// -------------------------------------------------------------------------

module write_id_pool #(
    parameter int NUM_IDS = 8
) (
    input  logic                          buf_clk_i,
    input  logic                          buf_rstn_i,
    input  logic                          id_take_i,   // grant_id_o goes busy
    input  logic                          bvalid_i,
    input  logic [axi_wr_pkg::AXI_IW-1:0] bid_i,
    output logic                          id_free_o,
    output logic [axi_wr_pkg::AXI_IW-1:0] grant_id_o
);

    import axi_wr_pkg::*;

    logic [NUM_IDS-1:0] busy_q;

    // ---------------------------------------------------------------------
    // busy flags
    always_ff @(posedge buf_clk_i) begin
        if (!buf_rstn_i) begin
            busy_q <= '0;
        end else begin
            for (int i = 0; i < NUM_IDS; i++) begin
                if (id_take_i && (grant_id_o == AXI_IW'(i))) begin
                    busy_q[i] <= 1'b1;
                end else if (bvalid_i && (bid_i == AXI_IW'(i))) begin
                    busy_q[i] <= 1'b0;  // response retires the burst
                end
            end
        end
    end

    assign id_free_o = ~&busy_q;

    // ---------------------------------------------------------------------
    // lowest free id, 0 when the pool is exhausted
    always_comb begin
        grant_id_o = '0;
        for (int i = NUM_IDS - 1; i >= 0; i--) begin
            if (!busy_q[i]) begin
                grant_id_o = AXI_IW'(i);
            end
        end
    end

endmodule

// File: verilog/ddr_ring_pointer.sv
// -------------------------------------------------------------------------
// DDR ring pointer
// write position of one channel inside its DDR ring buffer, steps by one
// half per dump, wraps to the base at the end and can be reloaded
// -------------------------------------------------------------------------

module ddr_ring_pointer (
    input  logic                          buf_clk_i,
    input  logic                          buf_rstn_i,
    input  logic [axi_wr_pkg::AXI_AW-1:0] base_i,
    input  logic [axi_wr_pkg::AXI_AW-1:0] end_i,     // one past the ring
    input  logic                          advance_i,
    input  logic                          reload_i,
    output logic [axi_wr_pkg::AXI_AW-1:0] curr_o
);

    import axi_wr_pkg::*;
    import dump_buf_pkg::*;

    logic [AXI_AW-1:0] next_pos;

    assign next_pos = curr_o + AXI_AW'(RING_STEP);

    always_ff @(posedge buf_clk_i) begin
        if (!buf_rstn_i) begin
            curr_o <= '0;
        end else if (advance_i) begin  // advance beats a reload
            curr_o <= (next_pos >= end_i) ? base_i : next_pos;
        end else if (reload_i) begin
            curr_o <= base_i;
        end
    end

endmodule

// File: verilog/burst_sequencer.sv
// -------------------------------------------------------------------------
// burst sequencer
// starts a half transfer when a half is pending and an id is free, splits
// it into fixed 16 beat bursts, reads the buffer beat by beat onto W and
// issues the matching AW addresses from the channel ring pointers
// -------------------------------------------------------------------------

module burst_sequencer #(
    parameter int NUM_IDS = 8
) (
    input  logic                            buf_clk_i,
    input  logic                            buf_rstn_i,
    // half-buffer tracker
    input  logic [3:0]                      pending_i,
    input  dump_buf_pkg::half_id_t          next_half_i,
    output logic                            half_done_o,
    output dump_buf_pkg::half_id_t          done_half_o,
    // write id pool
    input  logic                            id_free_i,
    input  logic [axi_wr_pkg::AXI_IW-1:0]   grant_id_i,
    output logic                            id_take_o,
    // sample buffer read port
    output logic [1:0]                      buf_select_o,  // one-hot A/B
    output logic [dump_buf_pkg::BUF_AW-1:0] buf_raddr_o,
    input  logic [axi_wr_pkg::AXI_DW-1:0]   buf_rdata_i,
    // AXI AW
    output logic [axi_wr_pkg::AXI_AW-1:0]   awaddr_o,
    output logic [axi_wr_pkg::AXI_IW-1:0]   awid_o,
    output logic                            awvalid_o,
    input  logic                            awready_i,
    // AXI W
    output logic [axi_wr_pkg::AXI_DW-1:0]   wdata_o,
    output logic [axi_wr_pkg::AXI_IW-1:0]   wid_o,
    output logic                            wlast_o,
    output logic                            wvalid_o,
    input  logic                            wready_i,
    // DDR rings
    input  logic [axi_wr_pkg::AXI_AW-1:0]   ddr_a_base_i,
    input  logic [axi_wr_pkg::AXI_AW-1:0]   ddr_a_end_i,
    input  logic [axi_wr_pkg::AXI_AW-1:0]   ddr_b_base_i,
    input  logic [axi_wr_pkg::AXI_AW-1:0]   ddr_b_end_i,
    input  logic [1:0]                      reload_i,      // A, B
    output logic [axi_wr_pkg::AXI_AW-1:0]   ddr_a_curr_o,
    output logic [axi_wr_pkg::AXI_AW-1:0]   ddr_b_curr_o
);

    import axi_wr_pkg::*;
    import dump_buf_pkg::*;

    // only as many id bits as the pool can hand out
    localparam int ID_IDX_W   = (NUM_IDS > 1) ? $clog2(NUM_IDS) : 1;
    localparam int LAST_BURST = HALF_BEATS / AXI_BEATS - 1;

    buf_addr_u           rd_addr_q;     // beat offered on W
    logic                tx_running_q;  // a half is being sent
    logic                ch_q;          // 0 = A, 1 = B
    logic                w_active_q;
    logic                aw_valid_q;
    logic [AXI_AW-1:0]   aw_addr_q;
    logic [ID_IDX_W-1:0] burst_id_q;

    logic                w_hs;
    logic                last_beat;
    logic                burst_end;
    logic                half_end;
    logic                aw_free;
    logic                start_tx;
    logic                next_burst;
    logic                launch;
    logic [AXI_AW-1:0]   ring_curr;

    // ---------------------------------------------------------------------
    // transfer and burst decisions
    assign w_hs      = w_active_q & wready_i;
    assign last_beat = (rd_addr_q.f.beat == 4'(AXI_BEATS - 1));
    assign burst_end = w_hs & last_beat;
    assign half_end  = burst_end & (rd_addr_q.f.burst == 7'(LAST_BURST));
    assign aw_free   = !aw_valid_q | awready_i;  // no address left waiting

    assign start_tx   = !tx_running_q & (|pending_i) & id_free_i & aw_free;
    assign next_burst = tx_running_q & id_free_i & aw_free
                      & ((burst_end & !half_end) | !w_active_q);
    assign launch     = start_tx | next_burst;

    assign ring_curr = next_half_i[1] ? ddr_b_curr_o : ddr_a_curr_o;

    always_ff @(posedge buf_clk_i) begin
        if (!buf_rstn_i) begin
            tx_running_q <= 1'b0;
            w_active_q   <= 1'b0;
            aw_valid_q   <= 1'b0;
        end else begin
            if (start_tx) begin
                tx_running_q <= 1'b1;
            end else if (half_end) begin
                tx_running_q <= 1'b0;
            end

            if (launch) begin
                w_active_q <= 1'b1;
                aw_valid_q <= 1'b1;
            end else begin
                if (burst_end) begin
                    w_active_q <= 1'b0;  // wait for an id
                end
                if (awready_i) begin
                    aw_valid_q <= 1'b0;
                end
            end
        end
    end

    // ---------------------------------------------------------------------
    // read address, burst address and id
    always_ff @(posedge buf_clk_i) begin
        if (start_tx) begin
            ch_q              <= next_half_i[1];
            rd_addr_q.f.half  <= next_half_i[0];
            rd_addr_q.f.burst <= '0;
            rd_addr_q.f.beat  <= '0;
            aw_addr_q         <= ring_curr;  // position before the advance
        end else begin
            if (w_hs && !half_end) begin
                rd_addr_q.flat <= rd_addr_q.flat + 1'b1;  // rolls into next burst
            end
            if (next_burst) begin
                aw_addr_q <= aw_addr_q + AXI_AW'(AXI_BURST_BYTES);
            end
        end

        if (launch) begin
            burst_id_q <= grant_id_i[ID_IDX_W-1:0];
        end
    end

    assign id_take_o   = launch;
    assign half_done_o = half_end;
    assign done_half_o = half_id_t'({ch_q, rd_addr_q.f.half});

    assign buf_select_o = w_active_q ? (ch_q ? 2'b10 : 2'b01) : 2'b00;
    assign buf_raddr_o  = rd_addr_q.flat;

    assign awaddr_o  = aw_addr_q;
    assign awid_o    = AXI_IW'(burst_id_q);
    assign awvalid_o = aw_valid_q;

    assign wdata_o  = buf_rdata_i;  // buffer read is combinational
    assign wid_o    = AXI_IW'(burst_id_q);
    assign wlast_o  = w_active_q & last_beat;
    assign wvalid_o = w_active_q;

    // ---------------------------------------------------------------------
    // ring pointers, stepped when their half starts
    ddr_ring_pointer u_ring_a (
        .buf_clk_i  (buf_clk_i),
        .buf_rstn_i (buf_rstn_i),
        .base_i     (ddr_a_base_i),
        .end_i      (ddr_a_end_i),
        .advance_i  (start_tx & !next_half_i[1]),
        .reload_i   (reload_i[0]),
        .curr_o     (ddr_a_curr_o)
    );

    ddr_ring_pointer u_ring_b (
        .buf_clk_i  (buf_clk_i),
        .buf_rstn_i (buf_rstn_i),
        .base_i     (ddr_b_base_i),
        .end_i      (ddr_b_end_i),
        .advance_i  (start_tx & next_half_i[1]),
        .reload_i   (reload_i[1]),
        .curr_o     (ddr_b_curr_o)
    );

endmodule

// File: verilog/dump2ddr_top.sv
// -------------------------------------------------------------------------
// DDR dump engine
// AXI write master copying the two channel sample buffers half by half
// into one DDR ring buffer per channel
// -------------------------------------------------------------------------

module dump2ddr_top #(
    parameter int NUM_IDS = axi_wr_pkg::AXI_ID_MAX  // 1 .. AXI_ID_MAX
) (
    input  logic                            buf_clk_i,
    input  logic                            buf_rstn_i,
    // sample buffers
    input  logic [3:0]                      buf_ready_i,   // Al, Ah, Bl, Bh
    output logic [1:0]                      buf_select_o,
    output logic [dump_buf_pkg::BUF_AW-1:0] buf_raddr_o,
    input  logic [axi_wr_pkg::AXI_DW-1:0]   buf_rdata_i,
    // configuration
    input  logic [1:0]                      dump_en_i,     // A, B
    input  logic [1:0]                      reload_i,      // A, B
    input  logic [axi_wr_pkg::AXI_AW-1:0]   ddr_a_base_i,
    input  logic [axi_wr_pkg::AXI_AW-1:0]   ddr_a_end_i,
    input  logic [axi_wr_pkg::AXI_AW-1:0]   ddr_b_base_i,
    input  logic [axi_wr_pkg::AXI_AW-1:0]   ddr_b_end_i,
    output logic [axi_wr_pkg::AXI_AW-1:0]   ddr_a_curr_o,
    output logic [axi_wr_pkg::AXI_AW-1:0]   ddr_b_curr_o,
    // AXI write master
    output logic [axi_wr_pkg::AXI_AW-1:0]   axi_awaddr_o,
    output logic [axi_wr_pkg::AXI_IW-1:0]   axi_awid_o,
    output logic                            axi_awvalid_o,
    input  logic                            axi_awready_i,
    output logic [axi_wr_pkg::AXI_DW-1:0]   axi_wdata_o,
    output logic [axi_wr_pkg::AXI_IW-1:0]   axi_wid_o,
    output logic                            axi_wlast_o,
    output logic                            axi_wvalid_o,
    input  logic                            axi_wready_i,
    input  logic [axi_wr_pkg::AXI_IW-1:0]   axi_bid_i,
    input  logic                            axi_bvalid_i,
    output logic                            axi_bready_o
);

    import axi_wr_pkg::*;
    import dump_buf_pkg::*;

    logic [3:0]        pending;
    half_id_t          next_half;
    logic              half_done;
    half_id_t          done_half;
    logic              id_free;
    logic [AXI_IW-1:0] grant_id;
    logic              id_take;

    assign axi_bready_o = 1'b1;  // responses are always accepted

    half_buffer_tracker u_tracker (
        .buf_clk_i   (buf_clk_i),
        .buf_rstn_i  (buf_rstn_i),
        .buf_ready_i (buf_ready_i),
        .dump_en_i   (dump_en_i),
        .half_done_i (half_done),
        .done_half_i (done_half),
        .pending_o   (pending),
        .next_half_o (next_half)
    );

    write_id_pool #(
        .NUM_IDS (NUM_IDS)
    ) u_id_pool (
        .buf_clk_i  (buf_clk_i),
        .buf_rstn_i (buf_rstn_i),
        .id_take_i  (id_take),
        .bvalid_i   (axi_bvalid_i),
        .bid_i      (axi_bid_i),
        .id_free_o  (id_free),
        .grant_id_o (grant_id)
    );

    burst_sequencer #(
        .NUM_IDS (NUM_IDS)
    ) u_sequencer (
        .buf_clk_i    (buf_clk_i),
        .buf_rstn_i   (buf_rstn_i),
        .pending_i    (pending),
        .next_half_i  (next_half),
        .half_done_o  (half_done),
        .done_half_o  (done_half),
        .id_free_i    (id_free),
        .grant_id_i   (grant_id),
        .id_take_o    (id_take),
        .buf_select_o (buf_select_o),
        .buf_raddr_o  (buf_raddr_o),
        .buf_rdata_i  (buf_rdata_i),
        .awaddr_o     (axi_awaddr_o),
        .awid_o       (axi_awid_o),
        .awvalid_o    (axi_awvalid_o),
        .awready_i    (axi_awready_i),
        .wdata_o      (axi_wdata_o),
        .wid_o        (axi_wid_o),
        .wlast_o      (axi_wlast_o),
        .wvalid_o     (axi_wvalid_o),
        .wready_i     (axi_wready_i),
        .ddr_a_base_i (ddr_a_base_i),
        .ddr_a_end_i  (ddr_a_end_i),
        .ddr_b_base_i (ddr_b_base_i),
        .ddr_b_end_i  (ddr_b_end_i),
        .reload_i     (reload_i),
        .ddr_a_curr_o (ddr_a_curr_o),
        .ddr_b_curr_o (ddr_b_curr_o)
    );

endmodule

// File: tb/tb_clock_gen.sv
// --------------------------------------------------------------------------
// testbench clock and reset
// 20 unit clock period, active low reset held for 4 cycles
// --------------------------------------------------------------------------

module tb_clock_gen (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    initial begin
        rstn_o = 1'b0;
        repeat (4) @(posedge clk_o);
        #2 rstn_o = 1'b1;  // released off the edge like other inputs
    end

endmodule

// File: tb/tb_ddr_slave.sv
// --------------------------------------------------------------------------
// sample buffer model and AXI write slave
// answers buffer reads with a word built from channel, half and beat, takes
// AW and W with random back-pressure, returns B responses late in any order
// --------------------------------------------------------------------------

module tb_ddr_slave (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  logic                            hold_b_i,      // withhold responses
    input  logic [1:0]                      buf_select_i,
    input  logic [dump_buf_pkg::BUF_AW-1:0] buf_raddr_i,
    output logic [axi_wr_pkg::AXI_DW-1:0]   buf_rdata_o,
    input  logic                            awvalid_i,
    input  logic [axi_wr_pkg::AXI_IW-1:0]   awid_i,
    output logic                            awready_o,
    input  logic                            wvalid_i,
    input  logic [axi_wr_pkg::AXI_IW-1:0]   wid_i,
    input  logic                            wlast_i,
    output logic                            wready_o,
    output logic                            bvalid_o,
    output logic [axi_wr_pkg::AXI_IW-1:0]   bid_o
);

    integer      seed = 72746;
    logic [63:0] aw_seen;  // address accepted per id
    logic [63:0] w_done;   // last beat accepted per id

    function automatic logic [63:0] model_word(input logic ch, input logic half,
                                               input logic [10:0] off);
        return {16'hD0D0, 7'd0, ch, half, 5'd0, off, 12'h5A5, off};
    endfunction

    assign buf_rdata_o = (buf_select_i == 2'b00) ? 64'd0
                       : model_word(buf_select_i[1], buf_raddr_i[11], buf_raddr_i[10:0]);

    initial begin
        logic [63:0] done_ids;
        int          start;
        int          pick;
        awready_o = 1'b0;  // idle bus before the first edge
        wready_o  = 1'b0;
        bvalid_o  = 1'b0;
        bid_o     = '0;
        forever begin
            @(posedge clk_i);
            if (!rstn_i) begin
                aw_seen   <= '0;
                w_done    <= '0;
                awready_o <= #2 1'b0;
                wready_o  <= #2 1'b0;
                bvalid_o  <= #2 1'b0;
                bid_o     <= #2 '0;
            end else begin
                if (awvalid_i && awready_o) aw_seen[awid_i] <= 1'b1;
                if (wvalid_i && wready_o && wlast_i) w_done[wid_i] <= 1'b1;
                awready_o <= #2 (($random(seed) & 3) != 0);
                wready_o  <= #2 (($random(seed) & 3) != 0);
                bvalid_o  <= #2 1'b0;
                // at most one response per cycle from a random start id
                done_ids = aw_seen & w_done;
                pick     = -1;
                if (!hold_b_i && (($random(seed) & 3) == 0)) begin
                    start = $random(seed) & 63;
                    for (int k = 0; k < 64; k++) begin
                        if (pick < 0 && done_ids[(start + k) % 64]) pick = (start + k) % 64;
                    end
                end
                if (pick >= 0) begin
                    aw_seen[pick] <= 1'b0;
                    w_done[pick]  <= 1'b0;
                    bvalid_o      <= #2 1'b1;
                    bid_o         <= #2 6'(pick);
                end
            end
        end
    end

endmodule

// File: tb/tb_dump2ddr.sv
// --------------------------------------------------------------------------
// testbench for the DDR dump engine
// dumps halves of both channels through a randomly stalling slave, checks
// addresses, data, bursts, ids, stalls, reset and reload against a model
// --------------------------------------------------------------------------

module tb_dump2ddr;

    localparam int          NUM_IDS = 4;
    localparam logic [31:0] A_BASE  = 32'h1000_0000;
    localparam logic [31:0] B_BASE  = 32'h2000_0000;
    localparam logic [31:0] RING_SZ = 32'd3 * 32'd16384;  // ring of 3 halves

    logic clk, rstn, hold_b, awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic [3:0]  buf_ready;
    logic [1:0]  dump_en, reload, buf_select;
    logic [11:0] buf_raddr;
    logic [63:0] buf_rdata, wdata, exp_wdata;
    logic [31:0] a_curr, b_curr, awaddr, exp_awaddr, aw_base, awaddr_q;
    logic [31:0] ring_pos [2];
    logic [5:0]  awid, wid, bid;
    logic [6:0]  aw_cnt;       // burst within the half on AW
    logic [10:0] w_cnt;        // beat within the half on W
    logic [63:0] id_busy, wdata_q;
    logic        aw_stall_q, w_stall_q;
    logic [1:0]  exp_order [16];
    int          aw_ptr, w_ptr, exp_wr, busy_cnt;
    int          errors = 0;
    int          timeouts = 0;

    tb_clock_gen u_clock (.clk_o(clk), .rstn_o(rstn));

    dump2ddr_top #(.NUM_IDS(NUM_IDS)) u_dump2ddr_top (
        .buf_clk_i(clk), .buf_rstn_i(rstn), .buf_ready_i(buf_ready),
        .buf_select_o(buf_select), .buf_raddr_o(buf_raddr), .buf_rdata_i(buf_rdata),
        .dump_en_i(dump_en), .reload_i(reload),
        .ddr_a_base_i(A_BASE), .ddr_a_end_i(A_BASE + RING_SZ),
        .ddr_b_base_i(B_BASE), .ddr_b_end_i(B_BASE + RING_SZ),
        .ddr_a_curr_o(a_curr), .ddr_b_curr_o(b_curr),
        .axi_awaddr_o(awaddr), .axi_awid_o(awid), .axi_awvalid_o(awvalid),
        .axi_awready_i(awready), .axi_wdata_o(wdata), .axi_wid_o(wid),
        .axi_wlast_o(wlast), .axi_wvalid_o(wvalid), .axi_wready_i(wready),
        .axi_bid_i(bid), .axi_bvalid_i(bvalid), .axi_bready_o(bready)
    );

    tb_ddr_slave u_slave (
        .clk_i(clk), .rstn_i(rstn), .hold_b_i(hold_b), .buf_select_i(buf_select),
        .buf_raddr_i(buf_raddr), .buf_rdata_o(buf_rdata), .awvalid_i(awvalid),
        .awid_i(awid), .awready_o(awready), .wvalid_i(wvalid), .wid_i(wid),
        .wlast_i(wlast), .wready_o(wready), .bvalid_o(bvalid), .bid_o(bid)
    );

    function automatic logic [63:0] model_word(input logic ch, input logic half,
                                               input logic [10:0] off);
        return {16'hD0D0, 7'd0, ch, half, 5'd0, off, 12'h5A5, off};
    endfunction

    function automatic logic [31:0] ring_next(input logic ch, input logic [31:0] pos);
        logic [31:0] base;
        base = ch ? B_BASE : A_BASE;
        return (pos + 32'd16384 >= base + RING_SZ) ? base : pos + 32'd16384;
    endfunction

    // --------------------------------------------------------------------------
    // reference model of the expected stream
    always_comb begin
        exp_awaddr = ((aw_cnt == 0) ? ring_pos[exp_order[aw_ptr][1]] : aw_base)
                   + 32'(aw_cnt) * 32'd128;
        exp_wdata  = model_word(exp_order[w_ptr][1], exp_order[w_ptr][0], w_cnt);
        busy_cnt   = $countones(id_busy);
    end

    always @(posedge clk) begin
        aw_stall_q <= rstn && awvalid && !awready;
        w_stall_q  <= rstn && wvalid && !wready;
        awaddr_q   <= awaddr;
        wdata_q    <= wdata;
        if (!rstn) begin
            aw_cnt      <= '0;
            w_cnt       <= '0;
            aw_ptr      <= 0;
            w_ptr       <= 0;
            id_busy     <= '0;
            ring_pos[0] <= '0;
            ring_pos[1] <= '0;
        end else begin
            if (reload[0]) ring_pos[0] <= A_BASE;
            if (reload[1]) ring_pos[1] <= B_BASE;
            if (bvalid) id_busy[bid] <= 1'b0;
            if (awvalid && awready) begin
                id_busy[awid] <= 1'b1;
                if (aw_cnt == 0) begin  // advance wins over reload
                    aw_base <= ring_pos[exp_order[aw_ptr][1]];
                    ring_pos[exp_order[aw_ptr][1]] <=
                        ring_next(exp_order[aw_ptr][1], ring_pos[exp_order[aw_ptr][1]]);
                end
                aw_cnt <= aw_cnt + 1'b1;
                if (aw_cnt == 7'd127) aw_ptr <= aw_ptr + 1;
            end
            if (wvalid && wready) begin
                w_cnt <= w_cnt + 1'b1;
                if (w_cnt == 11'd2047) w_ptr <= w_ptr + 1;
            end
        end
    end

    // --------------------------------------------------------------------------
    // stream checks
    a_awaddr: assert property (@(posedge clk) disable iff (!rstn)
        (awvalid && awready) |-> (awaddr == exp_awaddr))
        else flag_mismatch("awaddr", $sampled(exp_awaddr), $sampled(awaddr));
    a_aw_wanted: assert property (@(posedge clk) disable iff (!rstn)
        (awvalid && awready) |-> (aw_ptr < exp_wr))
        else note_failure("address write without a pending half");
    a_wdata: assert property (@(posedge clk) disable iff (!rstn)
        (wvalid && wready) |-> (wdata == exp_wdata))
        else flag_mismatch("wdata", $sampled(exp_wdata), $sampled(wdata));
    a_w_wanted: assert property (@(posedge clk) disable iff (!rstn)
        (wvalid && wready) |-> (w_ptr < exp_wr))
        else note_failure("data beat without a pending half");
    a_wlast: assert property (@(posedge clk) disable iff (!rstn)
        wvalid |-> (wlast == (w_cnt[3:0] == 4'hF)))
        else flag_mismatch("wlast", $sampled(w_cnt[3:0] == 4'hF), $sampled(wlast));
    a_aw_hold: assert property (@(posedge clk) disable iff (!rstn)
        aw_stall_q |-> (awvalid && awaddr == awaddr_q))
        else flag_mismatch("awaddr", $sampled(awaddr_q), $sampled(awaddr));
    a_w_hold: assert property (@(posedge clk) disable iff (!rstn)
        w_stall_q |-> (wvalid && wdata == wdata_q))
        else flag_mismatch("wdata", $sampled(wdata_q), $sampled(wdata));
    a_id_reuse: assert property (@(posedge clk) disable iff (!rstn)
        (awvalid && awready) |-> !id_busy[awid])
        else note_failure($sformatf("awid %0d reused before its response", $sampled(awid)));
    a_id_limit: assert property (@(posedge clk) disable iff (!rstn)
        (busy_cnt == NUM_IDS) |-> !awvalid)
        else note_failure("new address issued with all ids busy");
    a_bready: assert property (@(posedge clk) disable iff (!rstn)
        bready)
        else flag_mismatch("bready", 64'd1, $sampled(bready));

    // --------------------------------------------------------------------------
    // stimulus helpers
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic flag_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
        errors++;
        $display("ERROR %0t %s expected %h got %h", $time, name, exp, act);
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("%s at %0t", msg, $time);
    endtask

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            flag_mismatch(name, exp, act);
        end
    endtask

    task automatic pulse_ready(input logic [3:0] mask);
        for (int i = 0; i < 4; i++) begin  // priority order among enabled halves
            if (mask[i] && dump_en[i >> 1]) begin
                exp_order[exp_wr] = 2'(i);
                exp_wr++;
            end
        end
        step();
        buf_ready = mask;
        step();
        buf_ready = 4'b0000;
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (!(w_ptr == exp_wr && aw_ptr == exp_wr && busy_cnt == 0 && !awvalid && !wvalid)
               && n < limit) begin
            step();
            n++;
        end
        if (n >= limit) begin
            timeouts++;
            $display("timeout while waiting for the dump to finish");
        end
    endtask

    task automatic run_dumps();
        int n;
        n = 0;
        while (rstn !== 1'b1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        #2;
        if (rstn !== 1'b1) begin
            timeouts++;
            $display("timeout while waiting for the reset release");
            return;
        end
        check_value("awvalid", 0, awvalid);
        check_value("wvalid", 0, wvalid);
        check_value("buf_select", 0, buf_select);
        check_value("pending", 0, u_dump2ddr_top.pending);
        check_value("id_free", 1, u_dump2ddr_top.id_free);
        check_value("ddr_a_curr", 0, a_curr);
        check_value("ddr_b_curr", 0, b_curr);
        step();
        reload = 2'b11;
        step();
        reload = 2'b00;
        step();
        check_value("ddr_a_curr", A_BASE, a_curr);
        check_value("ddr_b_curr", B_BASE, b_curr);
        dump_en = 2'b11;  // all four halves at once
        pulse_ready(4'b1111);
        wait_idle(60000);
        if (timeouts != 0) return;
        dump_en = 2'b01;  // B pulses ignored while the A ring wraps
        pulse_ready(4'b1111);
        wait_idle(40000);
        if (timeouts != 0) return;
        hold_b = 1'b1;    // ids run out while responses are held
        pulse_ready(4'b0001);
        n = 0;
        while (busy_cnt != NUM_IDS && n < 2000) begin
            step();
            n++;
        end
        if (busy_cnt != NUM_IDS) begin
            timeouts++;
            $display("timeout while waiting for all write ids to be busy");
            return;
        end
        repeat (40) step();
        hold_b = 1'b0;
        wait_idle(20000);
    endtask

    initial begin
        buf_ready = 4'b0000;
        dump_en   = 2'b00;
        reload    = 2'b00;
        hold_b    = 1'b0;
        exp_wr    = 0;
        for (int i = 0; i < 16; i++) exp_order[i] = 2'b00;
        run_dumps();
        $display("checks done, errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
verilog/axi_wr_pkg.sv
verilog/dump_buf_pkg.sv
verilog/half_buffer_tracker.sv
verilog/write_id_pool.sv
verilog/ddr_ring_pointer.sv
verilog/burst_sequencer.sv
verilog/dump2ddr_top.sv
tb/tb_clock_gen.sv
tb/tb_ddr_slave.sv
tb/tb_dump2ddr.sv
